//--- verilog/rv_macros.svh
// RV32I build-wide constants: opcodes, reset PC, data memory depth and NOP encoding
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Program counter after reset
`define RV_RESET_PC 32'h0000_0000

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// Major opcodes
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_OP     7'b0110011

`endif

//--- verilog/rv_pkg.sv
// RV32I core types: words, register indices, ALU and writeback enums, pipeline structs
package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regIdx_t;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      aluPassB
   } aluOp_e;

   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbLink
   } wbSel_e;

   // Control word produced by decode
   typedef struct packed {
      regIdx_t     rs1;
      regIdx_t     rs2;
      regIdx_t     rd;
      word_t       imm;
      aluOp_e      aluOp;
      logic        useImm;
      logic        usePcA;
      logic        isBranch;
      logic [2:0]  funct3;
      logic        isJal;
      logic        isJalr;
      logic        memRead;
      logic        memWrite;
      logic        regWrite;
      wbSel_e      wbSel;
   } decoded_t;

   // Execute-to-writeback register contents
   typedef struct packed {
      word_t       pc;
      word_t       linkPc;
      word_t       aluOut;
      word_t       storeData;
      regIdx_t     rd;
      logic        regWrite;
      wbSel_e      wbSel;
      logic        memRead;
      logic        memWrite;
   } exResult_t;

endpackage

//--- verilog/rvDecode.sv
// RV32I decoder: splits instruction fields, builds the immediate and the control word
`timescale 1ns/1ps
`include "rv_macros.svh"

module rvDecode import rv_pkg::*; (
   input  word_t    inst,
   output decoded_t dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       altBit;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;
   aluOp_e     arithOp;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   // funct7 bit 5 selects sub and sra
   assign altBit = inst[30];

   assign immI = {{20{inst[31]}}, inst[31:20]};
   assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign immU = {inst[31:12], 12'b0};
   assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   // Register and immediate ALU operation from funct3
   always_comb
   begin
      case (funct3)
         3'b000:  arithOp = (opcode == `RV_OPC_OP && altBit) ? aluSub : aluAdd;
         3'b001:  arithOp = aluSll;
         3'b010:  arithOp = aluSlt;
         3'b011:  arithOp = aluSltu;
         3'b100:  arithOp = aluXor;
         3'b101:  arithOp = altBit ? aluSra : aluSrl;
         3'b110:  arithOp = aluOr;
         default: arithOp = aluAnd;
      endcase
   end

   always_comb
   begin
      // Defaults describe a NOP that writes nothing
      dec          = '0;
      dec.rs1      = inst[19:15];
      dec.rs2      = inst[24:20];
      dec.rd       = inst[11:7];
      dec.funct3   = funct3;
      dec.aluOp    = aluAdd;
      dec.wbSel    = wbAlu;
      case (opcode)
         `RV_OPC_LUI:
         begin
            dec.imm      = immU;
            dec.useImm   = 1'b1;
            dec.aluOp    = aluPassB;
            dec.regWrite = 1'b1;
         end
         `RV_OPC_AUIPC:
         begin
            dec.imm      = immU;
            dec.useImm   = 1'b1;
            dec.usePcA   = 1'b1;
            dec.regWrite = 1'b1;
         end
         `RV_OPC_JAL:
         begin
            dec.imm      = immJ;
            dec.useImm   = 1'b1;
            dec.usePcA   = 1'b1;
            dec.isJal    = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel    = wbLink;
         end
         `RV_OPC_JALR:
         begin
            dec.imm      = immI;
            dec.useImm   = 1'b1;
            dec.isJalr   = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel    = wbLink;
         end
         `RV_OPC_BRANCH:
         begin
            dec.imm      = immB;
            dec.isBranch = 1'b1;
         end
         `RV_OPC_LOAD:
         begin
            dec.imm      = immI;
            dec.useImm   = 1'b1;
            dec.memRead  = 1'b1;
            dec.regWrite = 1'b1;
            dec.wbSel    = wbMem;
         end
         `RV_OPC_STORE:
         begin
            dec.imm      = immS;
            dec.useImm   = 1'b1;
            dec.memWrite = 1'b1;
         end
         `RV_OPC_OPIMM:
         begin
            dec.imm      = immI;
            dec.useImm   = 1'b1;
            dec.aluOp    = arithOp;
            dec.regWrite = 1'b1;
         end
         `RV_OPC_OP:
         begin
            dec.aluOp    = arithOp;
            dec.regWrite = 1'b1;
         end
         default:
         begin
            dec.regWrite = 1'b0;
         end
      endcase
   end

endmodule

//--- verilog/rvRegFile.sv
// Integer register file: two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/1ps

module rvRegFile import rv_pkg::*; (
   input  logic    clk,
   input  regIdx_t rs1,
   input  regIdx_t rs2,
   output word_t   rd1,
   output word_t   rd2,
   input  logic    we,
   input  regIdx_t wa,
   input  word_t   wd
);

   // x1 to x31 only
   word_t regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && wa != '0)
         regs[wa] <= wd;
   end

   // Same-cycle write is not visible here, execute forwards it
   assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/rvExecute.sv
// Execute stage: operand forwarding, ALU, branch decision and redirect target
`timescale 1ns/1ps

module rvExecute import rv_pkg::*; (
   input  decoded_t  dec,
   input  word_t     pc,
   input  word_t     rd1,
   input  word_t     rd2,
   input  logic      wbValid,
   input  regIdx_t   wbRd,
   input  word_t     wbData,
   input  logic      valid,
   output exResult_t ex,
   output logic      redirect,
   output word_t     redirectPc
);

   word_t fwdA;
   word_t fwdB;
   word_t opA;
   word_t opB;
   word_t aluOut;
   word_t branchTarget;
   logic  taken;

   // Bypass from writeback
   assign fwdA = (wbValid && wbRd != '0 && wbRd == dec.rs1) ? wbData : rd1;
   assign fwdB = (wbValid && wbRd != '0 && wbRd == dec.rs2) ? wbData : rd2;

   assign opA = dec.usePcA ? pc : fwdA;
   assign opB = dec.useImm ? dec.imm : fwdB;

   always_comb
   begin
      case (dec.aluOp)
         aluSub:   aluOut = opA - opB;
         aluSll:   aluOut = opA << opB[4:0];
         aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
         aluSltu:  aluOut = {31'b0, opA < opB};
         aluXor:   aluOut = opA ^ opB;
         aluSrl:   aluOut = opA >> opB[4:0];
         aluSra:   aluOut = $unsigned($signed(opA) >>> opB[4:0]);
         aluOr:    aluOut = opA | opB;
         aluAnd:   aluOut = opA & opB;
         aluPassB: aluOut = opB;
         default:  aluOut = opA + opB;
      endcase
   end

   // Branch condition compares the forwarded registers
   always_comb
   begin
      case (dec.funct3)
         3'b000:  taken = (fwdA == fwdB);
         3'b001:  taken = (fwdA != fwdB);
         3'b100:  taken = $signed(fwdA) < $signed(fwdB);
         3'b101:  taken = $signed(fwdA) >= $signed(fwdB);
         3'b110:  taken = fwdA < fwdB;
         3'b111:  taken = fwdA >= fwdB;
         default: taken = 1'b0;
      endcase
   end

   // JAL and branches share the PC-relative adder
   assign branchTarget = pc + dec.imm;
   assign redirectPc   = dec.isJalr ? {aluOut[31:1], 1'b0} : branchTarget;
   assign redirect     = valid && ((dec.isBranch && taken) || dec.isJal || dec.isJalr);

   always_comb
   begin
      ex           = '0;
      ex.pc        = pc;
      ex.linkPc    = pc + 32'd4;
      ex.aluOut    = aluOut;
      ex.storeData = fwdB;
      ex.rd        = dec.rd;
      ex.regWrite  = dec.regWrite;
      ex.wbSel     = dec.wbSel;
      ex.memRead   = dec.memRead;
      ex.memWrite  = dec.memWrite;
   end

endmodule

//--- verilog/rvResult.sv
// Result stage: word-addressed data memory and writeback value selection
`timescale 1ns/1ps
`include "rv_macros.svh"

module rvResult import rv_pkg::*; (
   input  logic      clk,
   input  exResult_t exNext,
   input  exResult_t exWb,
   input  logic      wbValid,
   output word_t     wbData
);

   localparam int AddrBits = $clog2(`RV_DMEM_WORDS);

   word_t                dmem [0:`RV_DMEM_WORDS-1];
   logic [AddrBits-1:0]  wordIdx;
   word_t                loadWord;

   // Word address taken from the execute-side ALU result
   assign wordIdx = exNext.aluOut[AddrBits+1:2];

   always_ff @(posedge clk)
   begin
      if (exNext.memWrite)
         dmem[wordIdx] <= exNext.storeData;
   end

   // Synchronous read, word lands in time for writeback
   always_ff @(posedge clk)
   begin
      if (exNext.memRead)
         loadWord <= dmem[wordIdx];
   end

   always_comb
   begin
      if (!wbValid)
         wbData = '0;
      else
      begin
         case (exWb.wbSel)
            wbMem:   wbData = loadWord;
            wbLink:  wbData = exWb.linkPc;
            default: wbData = exWb.aluOut;
         endcase
      end
   end

endmodule

//--- verilog/rvCore.sv
// Three-stage RV32I core: fetch, execute and writeback with forwarding and branch squash
`timescale 1ns/1ps
`include "rv_macros.svh"

module rvCore import rv_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   output word_t   imemAddr,
   input  word_t   imemData,
   output logic    retireValid,
   output word_t   retirePc,
   output regIdx_t retireRd,
   output word_t   retireData
);

   // Fetch
   word_t     pc;

   // Execute slot
   word_t     exInst;
   word_t     exPc;
   logic      exValid;
   decoded_t  dec;
   word_t     rd1;
   word_t     rd2;
   exResult_t exOut;
   exResult_t exNext;
   logic      redirect;
   word_t     redirectPc;

   // Writeback slot
   exResult_t wbSlot;
   logic      wbValid;
   regIdx_t   wbRd;
   word_t     wbData;

   assign imemAddr = pc;

   // Control state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc      <= `RV_RESET_PC;
         exValid <= 1'b0;
         wbValid <= 1'b0;
      end
      else
      begin
         pc      <= redirect ? redirectPc : pc + 32'd4;
         exValid <= !redirect;
         wbValid <= exValid;
      end
   end

   // Pipeline payload, the wrong-path fetch becomes a NOP
   always_ff @(posedge clk)
   begin
      exInst <= redirect ? `RV_NOP : imemData;
      exPc   <= pc;
      wbSlot <= exNext;
   end

   rvDecode i_rvDecode (
      .inst (exInst),
      .dec  (dec)
   );

   rvRegFile i_rvRegFile (
      .clk (clk),
      .rs1 (dec.rs1),
      .rs2 (dec.rs2),
      .rd1 (rd1),
      .rd2 (rd2),
      .we  (wbValid & wbSlot.regWrite),
      .wa  (wbSlot.rd),
      .wd  (wbData)
   );

   rvExecute i_rvExecute (
      .dec        (dec),
      .pc         (exPc),
      .rd1        (rd1),
      .rd2        (rd2),
      .wbValid    (wbValid),
      .wbRd       (wbRd),
      .wbData     (wbData),
      .valid      (exValid),
      .ex         (exOut),
      .redirect   (redirect),
      .redirectPc (redirectPc)
   );

   // Squashed or empty slots must not touch state
   always_comb
   begin
      exNext          = exOut;
      exNext.regWrite = exOut.regWrite & exValid;
      exNext.memWrite = exOut.memWrite & exValid;
   end

   rvResult i_rvResult (
      .clk     (clk),
      .exNext  (exNext),
      .exWb    (wbSlot),
      .wbValid (wbValid),
      .wbData  (wbData)
   );

   // Stores and branches report rd zero
   assign wbRd = wbSlot.regWrite ? wbSlot.rd : '0;

   assign retireValid = wbValid;
   assign retirePc    = wbSlot.pc;
   assign retireRd    = wbRd;
   assign retireData  = wbData;

endmodule

//--- testbench/tbRvCore.sv
// Testbench for the RV32I core: program ROM, reference ISA model and retirement checker
`timescale 1ns/1ps
`include "rv_macros.svh"

module tbRvCore import rv_pkg::*; ();

   typedef struct packed {
      word_t   pc;
      regIdx_t rd;
      word_t   data;
   } retire_t;

   logic    clk;
   logic    rst;
   word_t   imemAddr;
   word_t   imemData;
   logic    retireValid;
   word_t   retirePc;
   regIdx_t retireRd;
   word_t   retireData;

   word_t   rom [0:1023];
   word_t   refRegs [0:31];
   word_t   refMem [0:`RV_DMEM_WORDS-1];
   retire_t expQ [$];
   integer  seed;
   int      nInst;
   int      expTotal;
   int      checks;
   int      errors;
   int      cyclesOut;
   logic    refReady;
   logic    finished;

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   rvCore i_rvCore (
      .clk         (clk),
      .rst         (rst),
      .imemAddr    (imemAddr),
      .imemData    (imemData),
      .retireValid (retireValid),
      .retirePc    (retirePc),
      .retireRd    (retireRd),
      .retireData  (retireData)
   );

   // Fetch port answers in the same cycle
   assign imemData = rom[imemAddr[11:2]];

   function automatic word_t rnd();
      return $random(seed);
   endfunction

   function automatic word_t encI(input logic [11:0] imm, input regIdx_t rs1,
                                  input logic [2:0] f3, input regIdx_t rd,
                                  input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2,
                                  input regIdx_t rs1, input logic [2:0] f3,
                                  input regIdx_t rd);
      return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
   endfunction

   function automatic word_t encS(input logic [11:0] imm, input regIdx_t rs2,
                                  input regIdx_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OPC_STORE};
   endfunction

   function automatic word_t encB(input logic [12:0] imm, input regIdx_t rs2,
                                  input regIdx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
   endfunction

   function automatic word_t encU(input logic [19:0] imm, input regIdx_t rd,
                                  input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t encJ(input logic [20:0] imm, input regIdx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
   endfunction

   task automatic emit(input word_t inst);
      rom[nInst] = inst;
      nInst++;
   endtask

   task automatic buildProgram();
      word_t      r;
      word_t      s;
      logic [2:0] f3;
      logic [6:0] f7;
      int         i;
      int         k;
      // Unused words hold addi x0,x0,index
      for (i = 0; i < 1024; i++)
         rom[i] = {i[11:0], 20'h00013};
      nInst = 0;
      for (i = 1; i < 32; i++)
      begin
         r = rnd();
         emit(encI(r[11:0], 5'd0, 3'b000, i[4:0], `RV_OPC_OPIMM));
      end
      // Random ALU mix with LUI and AUIPC
      for (i = 0; i < 200; i++)
      begin
         r  = rnd();
         s  = rnd();
         f3 = r[20:18];
         f7 = (r[21] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
         if (r[2:0] == 3'd0)
            emit(encU(s[19:0], r[7:3], `RV_OPC_LUI));
         else if (r[2:0] == 3'd1)
            emit(encU(s[19:0], r[7:3], `RV_OPC_AUIPC));
         else if (r[2:0] < 3'd5)
            emit(encR(f7, r[17:13], r[12:8], f3, r[7:3]));
         else if (f3 == 3'b001 || f3 == 3'b101)
            emit(encI({f7, s[4:0]}, r[12:8], f3, r[7:3], `RV_OPC_OPIMM));
         else
            emit(encI(s[11:0], r[12:8], f3, r[7:3], `RV_OPC_OPIMM));
      end
      // Back-to-back chains, load then immediate use
      emit(encI(12'd100, 5'd0, 3'b000, 5'd1, `RV_OPC_OPIMM));
      emit(encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
      emit(encR(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
      emit(encR(7'h00, 5'd2, 5'd3, 3'b100, 5'd4));
      emit(encS(12'd16, 5'd4, 5'd0));
      emit(encI(12'd16, 5'd0, 3'b010, 5'd6, `RV_OPC_LOAD));
      emit(encR(7'h00, 5'd6, 5'd6, 3'b000, 5'd7));
      emit(encS(12'd20, 5'd7, 5'd0));
      emit(encI(12'd20, 5'd0, 3'b010, 5'd8, `RV_OPC_LOAD));
      emit(encS(12'd24, 5'd8, 5'd0));
      emit(encI(12'd24, 5'd0, 3'b010, 5'd9, `RV_OPC_LOAD));
      emit(encI(12'd16, 5'd9, 3'b000, 5'd10, `RV_OPC_OPIMM));
      // Eight stores, read back in reverse order
      for (k = 0; k < 8; k++)
      begin
         r = rnd();
         s = 32'd256 + 4 * k;
         emit(encS(s[11:0], r[4:0], 5'd0));
      end
      for (k = 7; k >= 0; k--)
      begin
         s = 32'd256 + 4 * k;
         emit(encI(s[11:0], 5'd0, 3'b010, 5'd11 + k[4:0], `RV_OPC_LOAD));
      end
      // Operands -5, 7, 7 for the branch kinds
      emit(encI(-12'd5, 5'd0, 3'b000, 5'd21, `RV_OPC_OPIMM));
      emit(encI(12'd7, 5'd0, 3'b000, 5'd22, `RV_OPC_OPIMM));
      emit(encI(12'd7, 5'd0, 3'b000, 5'd23, `RV_OPC_OPIMM));
      for (k = 0; k < 8; k++)
      begin
         if (k != 2 && k != 3)
         begin
            f3 = k[2:0];
            emit(encB(13'd8, 5'd22, 5'd21, f3));
            emit(encI(12'd1, 5'd20, 3'b000, 5'd20, `RV_OPC_OPIMM));
            emit(encB(13'd8, 5'd23, 5'd22, f3));
            emit(encI(12'd1, 5'd20, 3'b000, 5'd20, `RV_OPC_OPIMM));
            emit(encB(13'd8, 5'd21, 5'd22, f3));
            emit(encI(12'd1, 5'd20, 3'b000, 5'd20, `RV_OPC_OPIMM));
         end
      end
      // Backward loop, three passes
      emit(encI(12'd3, 5'd0, 3'b000, 5'd24, `RV_OPC_OPIMM));
      emit(encI(-12'd1, 5'd24, 3'b000, 5'd24, `RV_OPC_OPIMM));
      emit(encB(-13'd4, 5'd0, 5'd24, 3'b001));
      // JAL skips one word, JALR target 13 lands on 12
      emit(encJ(21'd8, 5'd25));
      emit(encI(12'd1, 5'd20, 3'b000, 5'd20, `RV_OPC_OPIMM));
      emit(encU(20'd0, 5'd27, `RV_OPC_AUIPC));
      emit(encI(12'd13, 5'd27, 3'b000, 5'd28, `RV_OPC_JALR));
      emit(encI(12'd1, 5'd20, 3'b000, 5'd20, `RV_OPC_OPIMM));
      emit(encR(7'h00, 5'd25, 5'd28, 3'b000, 5'd29));
      emit(encJ(21'd0, 5'd0));
   endtask

   // ISA model of one instruction, returns the value written to dest
   function automatic word_t execRef(input word_t inst, input word_t pc,
                                     output word_t nextPc, output regIdx_t dest);
      word_t x;
      word_t y;
      word_t immI;
      word_t immS;
      word_t immB;
      word_t immJ;
      word_t res;
      logic  cond;
      x      = refRegs[inst[19:15]];
      y      = refRegs[inst[24:20]];
      immI   = {{20{inst[31]}}, inst[31:20]};
      immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      immB   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      immJ   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      nextPc = pc + 32'd4;
      dest   = inst[11:7];
      res    = '0;
      case (inst[6:0])
         `RV_OPC_LUI:   res = {inst[31:12], 12'h000};
         `RV_OPC_AUIPC: res = pc + {inst[31:12], 12'h000};
         `RV_OPC_JAL:
         begin
            res    = pc + 32'd4;
            nextPc = pc + immJ;
         end
         `RV_OPC_JALR:
         begin
            res    = pc + 32'd4;
            nextPc = (x + immI) & 32'hFFFF_FFFE;
         end
         `RV_OPC_BRANCH:
         begin
            dest = '0;
            case (inst[14:12])
               3'b000:  cond = (x == y);
               3'b001:  cond = (x != y);
               3'b100:  cond = ($signed(x) < $signed(y));
               3'b101:  cond = ($signed(x) >= $signed(y));
               3'b110:  cond = (x < y);
               default: cond = (x >= y);
            endcase
            if (cond)
               nextPc = pc + immB;
         end
         `RV_OPC_LOAD:  res = refMem[((x + immI) >> 2) % `RV_DMEM_WORDS];
         `RV_OPC_STORE:
         begin
            dest = '0;
            refMem[((x + immS) >> 2) % `RV_DMEM_WORDS] = y;
         end
         `RV_OPC_OP, `RV_OPC_OPIMM:
         begin
            if (inst[6:0] == `RV_OPC_OPIMM)
               y = immI;
            case (inst[14:12])
               3'b000:  res = (inst[6:0] == `RV_OPC_OP && inst[30]) ? x - y : x + y;
               3'b001:  res = x << y[4:0];
               3'b010:  res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
               3'b011:  res = (x < y) ? 32'd1 : 32'd0;
               3'b100:  res = x ^ y;
               3'b101:
               begin
                  if (inst[30])
                     res = $signed(x) >>> y[4:0];
                  else
                     res = x >> y[4:0];
               end
               3'b110:  res = x | y;
               default: res = x & y;
            endcase
         end
         default: dest = '0;
      endcase
      if (dest != '0)
         refRegs[dest] = res;
      return res;
   endfunction

   // Compares every retirement with the next expected entry
   always @(posedge clk)
   begin : checkRetire
      retire_t exp;
      if (rst)
      begin
         cyclesOut = 0;
         if (retireValid === 1'b1)
         begin
            errors++;
            $display("ERROR %0t: retireValid high during reset", $time);
         end
      end
      else if (!finished)
      begin
         cyclesOut = cyclesOut + 1;
         if (retireValid === 1'b1)
         begin
            if (checks == 0 && cyclesOut != 3)
            begin
               errors++;
               $display("ERROR %0t: first retirement %0d cycles after reset, expected 3",
                        $time, cyclesOut);
            end
            exp = expQ.pop_front();
            checks++;
            if (retirePc !== exp.pc || retireRd !== exp.rd ||
                (exp.rd != '0 && retireData !== exp.data))
            begin
               errors++;
               $display("ERROR %0t: retire %0d got pc %h rd %0d data %h", $time, checks,
                        retirePc, retireRd, retireData);
               $display("   expected pc %h rd %0d data %h", exp.pc, exp.rd, exp.data);
            end
            if (expQ.size() == 0)
               finished = 1'b1;
         end
      end
   end

   initial
   begin
      word_t   pc;
      word_t   nextPc;
      word_t   inst;
      regIdx_t dest;
      retire_t ent;
      int      i;
      rst      = 1'b1;
      seed     = 32'h92c6_5d63;
      checks   = 0;
      errors   = 0;
      finished = 1'b0;
      refReady = 1'b0;
      buildProgram();
      for (i = 0; i < 32; i++)
         refRegs[i] = '0;
      pc = `RV_RESET_PC;
      do
      begin
         inst     = rom[pc[11:2]];
         ent.pc   = pc;
         ent.data = execRef(inst, pc, nextPc, dest);
         ent.rd   = dest;
         expQ.push_back(ent);
         pc = nextPc;
      end while (inst != encJ(21'd0, 5'd0) && expQ.size() < 2000);
      expTotal = expQ.size();
      refReady = 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      wait (finished);
      $display("Errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // Watchdog, reset plus three cycles per instruction and 100 spare
   initial
   begin
      wait (refReady);
      repeat (10 + 3 * expTotal + 100) @(posedge clk);
      $display("Retirement stalled: only %0d of %0d instructions retired before the timeout",
               checks, expTotal);
      $display("Errors: %0d, checks: %0d", errors + 1, checks);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rvDecode.sv
verilog/rvRegFile.sv
verilog/rvExecute.sv
verilog/rvResult.sv
verilog/rvCore.sv
testbench/tbRvCore.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/rvDecode.sv
      - verilog/rvRegFile.sv
      - verilog/rvExecute.sv
      - verilog/rvResult.sv
      - verilog/rvCore.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tbRvCore.sv
